//--- Makefile
TOP := snake_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "=== PASS ==="

clean:
	rm -rf obj_dir

//--- design/pixel_writer.sv
`timescale 1ns/1ps

module pixel_writer
  import snake_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       vga_px_waitrequest,
  output bus_addr_t  vga_px_address,
  output logic       vga_px_write,
  output colour_t    vga_px_writedata,
  px_req_if.writer   px
);

  typedef enum logic [1:0] {
    W_IDLE,
    W_SINGLE,
    W_SWEEP
  } wr_state_t;

  wr_state_t state;
  coord_x_t  cnt_x;        // current column
  coord_y_t  cnt_y;        // current row
  coord_x_t  next_x;
  coord_y_t  next_y;
  coord_x_t  ax;           // column on the bus
  coord_y_t  ay;
  logic      fire;
  logic      last_px;

  assign fire    = vga_px_write && !vga_px_waitrequest;
  assign last_px = (cnt_x == coord_x_t'(NUM_X_PIXELS - 1)) &&
                   (cnt_y == coord_y_t'(NUM_Y_PIXELS - 1));

  // row-major step
  always_comb begin
    if (cnt_x == coord_x_t'(NUM_X_PIXELS - 1)) begin
      next_x = '0;
      next_y = cnt_y + 8'd1;
    end else begin
      next_x = cnt_x + 9'd1;
      next_y = cnt_y;
    end
  end

  // single writes use the cell the controller holds
  assign ax = (state == W_SWEEP) ? cnt_x : px.x;
  assign ay = (state == W_SWEEP) ? cnt_y : px.y;

  assign vga_px_write     = (state != W_IDLE);
  assign vga_px_address   = VGA_PX_BASE | (bus_addr_t'(ay) << MSG_Y_OFFSET)
                                        | (bus_addr_t'(ax) << MSG_X_OFFSET);
  assign vga_px_writedata = (state == W_SWEEP) ? bg_colour(cnt_x, cnt_y) : px.colour;
  assign px.done          = fire && ((state == W_SINGLE) || last_px);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= W_IDLE;
      cnt_x <= '0;
      cnt_y <= '0;
    end else if (px.abort) begin
      state <= W_IDLE;
    end else begin
      case (state)
        W_IDLE: begin
          if (px.draw) begin
            state <= W_SINGLE;
          end else if (px.clear) begin
            state <= W_SWEEP;
            cnt_x <= '0;
            cnt_y <= '0;
          end
        end
        W_SINGLE: if (fire) state <= W_IDLE;
        W_SWEEP: begin
          if (fire && last_px) begin
            state <= W_IDLE;
          end else if (fire) begin
            cnt_x <= next_x;
            cnt_y <= next_y;
          end
        end
        default: state <= W_IDLE;
      endcase
    end
  end

  a_hold_req: assert property (@(posedge clk) disable iff (!arst_n)
    vga_px_write && vga_px_waitrequest && !px.abort |=>
      vga_px_write && $stable(vga_px_address) && $stable(vga_px_writedata));

endmodule

//--- design/px_req_if.sv
`timescale 1ns/1ps

interface px_req_if
  import snake_pkg::*;
();

  logic     draw;    // single cell pulse
  logic     clear;   // start screen sweep
  logic     abort;   // game reset, drop any running write
  coord_x_t x;
  coord_y_t y;
  colour_t  colour;
  logic     done;    // last write finished

  modport ctrl (output draw, clear, abort, x, y, colour, input done);
  modport writer (input draw, clear, abort, x, y, colour, output done);

endinterface

//--- design/score_display.sv
`timescale 1ns/1ps

module score_display
  import snake_pkg::*;
(
  input  logic         clk,
  input  logic         arst_n,
  input  score_t       score,
  input  logic         score_load,
  input  logic         vga_ch_waitrequest,
  output bus_addr_t    vga_ch_address,
  output logic         vga_ch_write,
  output logic [15:0]  vga_ch_writedata
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_CONV,
    S_WRITE
  } sd_state_t;

  sd_state_t                   state;
  logic [3:0]                  bit_cnt;     // conversion step
  logic [2:0]                  dig_cnt;     // digit being written
  score_t                      bin;
  logic [SCORE_DIGITS*4-1:0]   bcd;
  logic [SCORE_DIGITS*4-1:0]   bcd_adj;
  logic                        pend_valid;
  score_t                      pend_score;
  logic                        start;
  score_t                      start_val;
  logic [3:0]                  cur_digit;
  logic                        fire;

  assign start     = (state == S_IDLE) && (score_load || pend_valid);
  assign start_val = score_load ? score : pend_score;  // newest value wins
  assign fire      = vga_ch_write && !vga_ch_waitrequest;

  // add 3 to any digit of 5 or more before the shift
  always_comb begin
    for (int i = 0; i < SCORE_DIGITS; i++) begin
      bcd_adj[i*4 +: 4] = (bcd[i*4 +: 4] >= 4'd5) ? bcd[i*4 +: 4] + 4'd3 : bcd[i*4 +: 4];
    end
  end

  assign cur_digit        = bcd[(SCORE_DIGITS - 1 - int'(dig_cnt))*4 +: 4];  // msd first
  assign vga_ch_write     = (state == S_WRITE);
  assign vga_ch_address   = VGA_CH_BASE + bus_addr_t'(dig_cnt);
  assign vga_ch_writedata = {8'h00, 8'h30 + {4'h0, cur_digit}};  // ascii

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= S_IDLE;
      bit_cnt    <= '0;
      dig_cnt    <= '0;
      pend_valid <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (start) begin
            state   <= S_CONV;
            bit_cnt <= '0;
          end
        end
        S_CONV: begin
          bit_cnt <= bit_cnt + 4'd1;
          if (bit_cnt == 4'($bits(score_t) - 1)) begin
            state   <= S_WRITE;
            dig_cnt <= '0;
          end
        end
        S_WRITE: begin
          if (fire && dig_cnt == 3'(SCORE_DIGITS - 1)) state <= S_IDLE;
          else if (fire) dig_cnt <= dig_cnt + 3'd1;
        end
        default: state <= S_IDLE;
      endcase
      if (start) pend_valid <= 1'b0;
      else if (score_load) pend_valid <= 1'b1;  // busy so replay later
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      bin <= start_val;
      bcd <= '0;
    end else if (state == S_CONV) begin
      {bcd, bin} <= {bcd_adj[SCORE_DIGITS*4-2:0], bin, 1'b0};
    end
    if (score_load && !start) pend_score <= score;
  end

  // every digit sent out is a decimal digit
  a_decimal_digit: assert property (@(posedge clk) disable iff (!arst_n)
    vga_ch_write |-> cur_digit <= 4'd9);

endmodule

//--- design/snake_ctrl.sv
`timescale 1ns/1ps

module snake_ctrl
  import snake_pkg::*;
(
  input  logic         clk,
  input  logic         arst_n,
  input  logic [3:0]   hps_address,
  input  logic         hps_read,
  input  logic         hps_write,
  input  logic [31:0]  hps_writedata,
  output logic         hps_waitrequest,
  output logic [31:0]  hps_readdata,
  output ctrl_state_t  state_export,
  output score_t       score,
  output logic         score_load,
  px_req_if.ctrl       px
);

  ctrl_state_t state;
  cmd_t        hps_cmd;
  coord_x_t    hps_x;
  coord_y_t    hps_y;
  logic        reset_word;
  logic        accept;
  logic        cell_cmd;       // add or delete of a cell
  colour_t     cell_colour;
  coord_x_t    x_q;
  coord_y_t    y_q;
  colour_t     colour_q;

  assign hps_cmd = hps_writedata[31:MSG_CMD_OFFSET];
  assign hps_y   = hps_writedata[MSG_CMD_OFFSET-1:MSG_Y_OFFSET];
  assign hps_x   = hps_writedata[MSG_Y_OFFSET-1:MSG_X_OFFSET];

  // the reset word gets through even while a write is in flight
  assign reset_word      = hps_write && (hps_writedata == RESET_GAME);
  assign hps_waitrequest = ((state == DRAWING) || (state == CLEARING)) && !reset_word;
  assign accept          = hps_write && !hps_waitrequest && !reset_word;

  assign hps_readdata = (hps_read && hps_address == 4'd0) ? {14'd0, state, score} : '0;
  assign state_export = state;

  always_comb begin
    cell_cmd    = 1'b1;
    cell_colour = bg_colour(hps_x, hps_y);  // deletes restore background
    case (hps_cmd)
      CMD_SNAKE_ADD:        cell_colour = SNAKE_COLOUR;
      CMD_APPLE_ADD:        cell_colour = APPLE_COLOUR;
      CMD_GOLDEN_APPLE_ADD: cell_colour = GAPPLE_COLOUR;
      CMD_SPEED_UP_ADD:     cell_colour = SPEED_UP_COLOUR;
      CMD_SNAKE_DEL, CMD_APPLE_DEL, CMD_GOLDEN_APPLE_DEL, CMD_SPEED_UP_DEL: ;
      default:              cell_cmd = 1'b0;
    endcase
  end

  assign px.draw  = accept && (state == PLAYING) && cell_cmd;
  assign px.clear = accept && (state == WAITING) && (hps_cmd == CMD_START_GAME);
  assign px.abort = reset_word;

  // decoded cell in the accept cycle and the held copy after it
  assign px.x      = (state == PLAYING) ? hps_x : x_q;
  assign px.y      = (state == PLAYING) ? hps_y : y_q;
  assign px.colour = (state == PLAYING) ? cell_colour : colour_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= WAITING;
      score      <= '0;
      score_load <= 1'b0;
    end else begin
      score_load <= 1'b0;
      if (reset_word) begin
        state      <= WAITING;
        score      <= '0;
        score_load <= 1'b1;                 // show zero again
      end else begin
        case (state)
          WAITING: if (px.clear) state <= CLEARING;
          PLAYING: begin
            if (px.draw) begin
              state <= DRAWING;
            end else if (accept && hps_cmd == CMD_NEW_SCORE) begin
              score      <= hps_writedata[15:0];
              score_load <= 1'b1;
            end else if (accept && hps_cmd == CMD_END_GAME) begin
              state <= WAITING;
            end
          end
          DRAWING, CLEARING: if (px.done) state <= PLAYING;
          default: state <= WAITING;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (px.draw) begin
      x_q      <= hps_x;
      y_q      <= hps_y;
      colour_q <= cell_colour;
    end
  end

  // the writer only answers a request that is still outstanding
  a_done_expected: assert property (@(posedge clk) disable iff (!arst_n)
    px.done |-> (state == DRAWING) || (state == CLEARING));

endmodule

//--- design/snake_pkg.sv
package snake_pkg;

  // host word layout
  localparam int MSG_CMD_OFFSET = 18;
  localparam int MSG_Y_OFFSET   = 10;
  localparam int MSG_X_OFFSET   = 1;

  localparam int NUM_X_PIXELS = 320;     // column count
  localparam int NUM_Y_PIXELS = 240;     // row count
  localparam int SCORE_DIGITS = 5;

  typedef logic [8:0]  coord_x_t;
  typedef logic [7:0]  coord_y_t;
  typedef logic [15:0] colour_t;         // rgb565
  typedef logic [13:0] cmd_t;
  typedef logic [15:0] score_t;
  typedef logic [31:0] bus_addr_t;

  typedef enum logic [1:0] {
    WAITING  = 2'd0,
    PLAYING  = 2'd1,
    DRAWING  = 2'd2,
    CLEARING = 2'd3
  } ctrl_state_t;

  localparam bus_addr_t VGA_PX_BASE = 32'h0800_0000;
  localparam bus_addr_t VGA_CH_BASE = 32'h0900_0000;

  localparam colour_t SNAKE_COLOUR    = 16'h07E0;  // green
  localparam colour_t APPLE_COLOUR    = 16'hF800;  // red
  localparam colour_t GAPPLE_COLOUR   = 16'hFEA0;  // gold
  localparam colour_t SPEED_UP_COLOUR = 16'h001F;  // blue
  localparam colour_t BLACK           = 16'h0000;
  localparam colour_t GRAY            = 16'h8410;

  localparam cmd_t CMD_START_GAME       = 14'd1;
  localparam cmd_t CMD_END_GAME         = 14'd2;
  localparam cmd_t CMD_SNAKE_ADD        = 14'd3;
  localparam cmd_t CMD_SNAKE_DEL        = 14'd4;
  localparam cmd_t CMD_NEW_SCORE        = 14'd5;
  localparam cmd_t CMD_APPLE_ADD        = 14'd6;
  localparam cmd_t CMD_APPLE_DEL        = 14'd7;
  localparam cmd_t CMD_GOLDEN_APPLE_ADD = 14'd8;
  localparam cmd_t CMD_GOLDEN_APPLE_DEL = 14'd9;
  localparam cmd_t CMD_SPEED_UP_ADD     = 14'd10;
  localparam cmd_t CMD_SPEED_UP_DEL     = 14'd11;

  localparam logic [31:0] RESET_GAME = 32'hFFFF_FFFF;  // whole word, not a code

  // checkerboard background of an empty cell
  function automatic colour_t bg_colour(coord_x_t x, coord_y_t y);
    return (x[0] ^ y[0]) ? BLACK : GRAY;
  endfunction

endpackage

//--- design/snake_top.sv
`timescale 1ns/1ps

module snake_top
  import snake_pkg::*;
(
  input  logic         clk,
  input  logic         arst_n,
  // host slave
  input  logic [3:0]   hps_address,
  input  logic         hps_read,
  input  logic         hps_write,
  input  logic [31:0]  hps_writedata,
  output logic         hps_waitrequest,
  output logic [31:0]  hps_readdata,
  output ctrl_state_t  state_export,
  // pixel buffer master
  input  logic         vga_px_waitrequest,
  output bus_addr_t    vga_px_address,
  output logic         vga_px_write,
  output colour_t      vga_px_writedata,
  // character buffer master
  input  logic         vga_ch_waitrequest,
  output bus_addr_t    vga_ch_address,
  output logic         vga_ch_write,
  output logic [15:0]  vga_ch_writedata
);

  score_t score;
  logic   score_load;

  px_req_if u_px_if ();

  snake_ctrl u_ctrl (
    .clk             (clk),
    .arst_n          (arst_n),
    .hps_address     (hps_address),
    .hps_read        (hps_read),
    .hps_write       (hps_write),
    .hps_writedata   (hps_writedata),
    .hps_waitrequest (hps_waitrequest),
    .hps_readdata    (hps_readdata),
    .state_export    (state_export),
    .score           (score),
    .score_load      (score_load),
    .px              (u_px_if.ctrl)
  );

  pixel_writer u_pixel_writer (
    .clk                (clk),
    .arst_n             (arst_n),
    .vga_px_waitrequest (vga_px_waitrequest),
    .vga_px_address     (vga_px_address),
    .vga_px_write       (vga_px_write),
    .vga_px_writedata   (vga_px_writedata),
    .px                 (u_px_if.writer)
  );

  score_display u_score_display (
    .clk                (clk),
    .arst_n             (arst_n),
    .score              (score),
    .score_load         (score_load),
    .vga_ch_waitrequest (vga_ch_waitrequest),
    .vga_ch_address     (vga_ch_address),
    .vga_ch_write       (vga_ch_write),
    .vga_ch_writedata   (vga_ch_writedata)
  );

endmodule

//--- filelist.f
design/snake_pkg.sv
design/px_req_if.sv
design/snake_ctrl.sv
design/pixel_writer.sv
design/score_display.sv
design/snake_top.sv
test/snake_tb.sv

//--- test/snake_tb.sv
`timescale 1ns/1ps

module snake_tb
  import snake_pkg::*;
();

  localparam int NUM_RANDOM  = 40;
  localparam int NUM_CMDS    = NUM_RANDOM + 12;
  localparam int SWEEP_PX    = NUM_X_PIXELS * NUM_Y_PIXELS;
  localparam int CYCLE_LIMIT = 3 * (2 * SWEEP_PX) + 200 * NUM_CMDS;
  localparam logic [15:0] SEED = 16'd40078;

  logic        clk;
  logic        arst_n;
  logic [3:0]  hps_address;
  logic        hps_read;
  logic        hps_write;
  logic [31:0] hps_writedata;
  logic        hps_waitrequest;
  logic [31:0] hps_readdata;
  ctrl_state_t state_export;
  logic        vga_px_waitrequest;
  bus_addr_t   vga_px_address;
  logic        vga_px_write;
  colour_t     vga_px_writedata;
  logic        vga_ch_waitrequest;
  bus_addr_t   vga_ch_address;
  logic        vga_ch_write;
  logic [15:0] vga_ch_writedata;

  colour_t     px_mem[bus_addr_t];   // pixel buffer model
  int          px_hits[bus_addr_t];
  int          px_count = 0;
  logic [7:0]  ch_mem[bus_addr_t];   // character buffer model
  int          ch_count = 0;
  logic [15:0] wr_lfsr;
  logic [15:0] stim_lfsr = SEED;
  int          cycles;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  string       waiting_on = "reset";
  cmd_t        cell_cmds[8] = '{CMD_SNAKE_ADD, CMD_SNAKE_DEL, CMD_APPLE_ADD, CMD_APPLE_DEL,
                                CMD_GOLDEN_APPLE_ADD, CMD_GOLDEN_APPLE_DEL,
                                CMD_SPEED_UP_ADD, CMD_SPEED_UP_DEL};

  snake_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // galois x^16+x^14+x^13+x^11+1
  endfunction

  // one lfsr step per bit taken
  function automatic logic [15:0] take_bits(int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v         = {v[14:0], stim_lfsr[0]};
      stim_lfsr = lfsr_next(stim_lfsr);
    end
    return v;
  endfunction

  // both buffers stall at random with one bit per port per cycle
  initial begin
    wr_lfsr            = SEED;
    vga_px_waitrequest = 1'b0;
    vga_ch_waitrequest = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      vga_px_waitrequest = wr_lfsr[0];
      wr_lfsr            = lfsr_next(wr_lfsr);
      vga_ch_waitrequest = wr_lfsr[0];
      wr_lfsr            = lfsr_next(wr_lfsr);
    end
  end

  // sampled mid-cycle where values match the completing edge
  always @(negedge clk) begin
    if (vga_px_write && !vga_px_waitrequest) begin
      px_mem[vga_px_address]  = vga_px_writedata;
      px_hits[vga_px_address] = px_hits.exists(vga_px_address) ?
                                px_hits[vga_px_address] + 1 : 1;
      px_count++;
    end
    if (vga_ch_write && !vga_ch_waitrequest) begin
      ch_mem[vga_ch_address] = vga_ch_writedata[7:0];
      ch_count++;
    end
  end

  initial begin
    cycles = 0;
    while (cycles <= CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, stalled on %s", cycles, waiting_on);
    $display("=== FAIL ===");
    $finish;
  end

  function automatic colour_t expected_colour(cmd_t cmd, coord_x_t x, coord_y_t y);
    case (cmd)
      CMD_SNAKE_ADD:        return SNAKE_COLOUR;
      CMD_APPLE_ADD:        return APPLE_COLOUR;
      CMD_GOLDEN_APPLE_ADD: return GAPPLE_COLOUR;
      CMD_SPEED_UP_ADD:     return SPEED_UP_COLOUR;
      default:              return (x[0] != y[0]) ? BLACK : GRAY;  // deletes and sweep
    endcase
  endfunction

  function automatic logic [7:0] expected_char(score_t s, int k);
    int d;
    d = (int'(s) / (10 ** (SCORE_DIGITS - 1 - k))) % 10;  // k = 0 is the msd
    return 8'h30 + 8'(d);
  endfunction

  function automatic logic [31:0] cell_word(cmd_t cmd, coord_x_t x, coord_y_t y);
    return {cmd, y, x, 1'b0};
  endfunction

  function automatic bus_addr_t px_addr(coord_x_t x, coord_y_t y);
    return VGA_PX_BASE | (bus_addr_t'(y) << MSG_Y_OFFSET) | (bus_addr_t'(x) << MSG_X_OFFSET);
  endfunction

  task automatic flag_failure(string msg);
    errors++;
    $display("%s", msg);
  endtask

  task automatic check_colour(string name, colour_t exp, colour_t act);
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_char(string name, logic [7:0] exp, logic [7:0] act);
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_state(string name, ctrl_state_t exp, ctrl_state_t act);
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected %s, actual %s (%0d)", name, exp.name(), act.name(), act);
    end
  endtask

  task automatic check_score(string name, score_t exp, score_t act);
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic close_test(string name, int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - err_before);
    end
  endtask

  // called 1 ns after an edge, returns 1 ns after the accepting edge
  task automatic host_write(logic [31:0] word);
    waiting_on    = "host write, hps_waitrequest never fell";
    hps_write     = 1'b1;
    hps_writedata = word;
    #1;
    while (hps_waitrequest) begin
      @(posedge clk);
      #2;
    end
    @(posedge clk);
    #1;
    hps_write = 1'b0;
  endtask

  task automatic check_status(string name, ctrl_state_t exp_state, score_t exp_score);
    logic [31:0] rd;
    hps_read    = 1'b1;
    hps_address = 4'd0;
    #1;
    rd = hps_readdata;                      // zero wait read
    @(posedge clk);
    #1;
    hps_read = 1'b0;
    check_state({name, " state"}, exp_state, ctrl_state_t'(rd[17:16]));
    check_score({name, " score"}, exp_score, rd[15:0]);
  endtask

  task automatic wait_ready(string what);
    waiting_on = what;
    while (hps_waitrequest) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic wait_chars(int target);
    waiting_on = "character writes, vga_ch_write never finished";
    while (ch_count < target || vga_ch_write) begin
      @(posedge clk);
      #1;
    end
    if (ch_count != target)
      flag_failure($sformatf("%0d character writes where %0d were due", ch_count, target));
  endtask

  task automatic check_digits(string name, score_t s);
    bus_addr_t a;
    for (int k = 0; k < SCORE_DIGITS; k++) begin
      a = VGA_CH_BASE + bus_addr_t'(k);
      if (!ch_mem.exists(a)) flag_failure($sformatf("%s: digit %0d never written", name, k));
      else check_char($sformatf("%s digit %0d", name, k), expected_char(s, k), ch_mem[a]);
    end
  endtask

  initial begin
    cmd_t      cmd;
    coord_x_t  x;
    coord_y_t  y;
    bus_addr_t a;
    int        n;
    int        hits;
    int        c;
    int        err0;
    score_t    s_a;
    score_t    s_b;
    string     name;
    hps_address   = '0;
    hps_read      = 1'b0;
    hps_write     = 1'b0;
    hps_writedata = '0;
    arst_n        = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    arst_n = 1'b1;

    err0 = errors;
    if (vga_px_write || vga_ch_write || hps_waitrequest)
      flag_failure("a write strobe or hps_waitrequest is high after reset");
    check_status("reset", WAITING, '0);
    close_test("reset", err0);

    err0 = errors;
    host_write(cell_word(CMD_SNAKE_ADD, 9'd5, 8'd7));
    host_write(cell_word(CMD_APPLE_DEL, 9'd6, 8'd7));
    repeat (20) @(posedge clk);            // nothing may reach the pixel port
    #1;
    if (px_count != 0) flag_failure("pixel write issued before the game started");
    check_state("waiting ignores cells", WAITING, state_export);
    host_write(cell_word(CMD_START_GAME, '0, '0));
    wait_ready("screen sweep, vga_px_write never finished");
    if (px_count != SWEEP_PX || px_hits.num() != SWEEP_PX)
      flag_failure($sformatf("sweep made %0d writes to %0d addresses", px_count, px_hits.num()));
    for (int row = 0; row < NUM_Y_PIXELS && errors < err0 + 10; row++) begin
      for (int col = 0; col < NUM_X_PIXELS; col++) begin
        a = px_addr(coord_x_t'(col), coord_y_t'(row));
        if (!px_hits.exists(a) || px_hits[a] != 1)
          flag_failure($sformatf("sweep pixel %0d,%0d not written exactly once", col, row));
        else
          check_colour($sformatf("sweep %0d,%0d", col, row),
                       expected_colour(CMD_SNAKE_DEL, coord_x_t'(col), coord_y_t'(row)),
                       px_mem[a]);
      end
    end
    check_status("start game", PLAYING, '0);
    close_test("start game sweep", err0);

    err0 = errors;
    for (int i = 0; i < NUM_RANDOM; i++) begin
      cmd = cell_cmds[3'(take_bits(3))];
      x   = coord_x_t'(take_bits(9));
      y   = coord_y_t'(take_bits(8));
      if (x >= 9'd320) x = x - 9'd320;     // fold onto the screen
      if (y >= 8'd240) y = y - 8'd240;
      a    = px_addr(x, y);
      hits = px_hits.exists(a) ? px_hits[a] : 0;
      n    = px_count;
      name = $sformatf("cmd %0d at %0d,%0d", cmd, x, y);
      host_write(cell_word(cmd, x, y));
      check_state({name, " host stall"}, DRAWING, state_export);
      wait_ready("cell write, vga_px_write never finished");
      if (px_count != n + 1 || px_hits[a] != hits + 1)
        flag_failure($sformatf("%s: pixel write missing or misplaced", name));
      else
        check_colour(name, expected_colour(cmd, x, y), px_mem[a]);
    end
    close_test("random cells", err0);

    err0 = errors;
    s_a = score_t'(take_bits(16));
    n   = ch_count;
    host_write({CMD_NEW_SCORE, 2'b00, s_a});
    wait_chars(n + SCORE_DIGITS);
    check_digits("single score", s_a);
    s_a = score_t'(take_bits(16));
    s_b = score_t'(take_bits(16));
    n   = ch_count;
    host_write({CMD_NEW_SCORE, 2'b00, s_a});
    host_write({CMD_NEW_SCORE, 2'b00, s_b}); // lands while the first converts
    wait_chars(n + 2 * SCORE_DIGITS);
    check_digits("two scores", s_b);
    check_status("score read", PLAYING, s_b);
    close_test("new score", err0);

    err0 = errors;
    host_write(cell_word(CMD_END_GAME, '0, '0));
    check_status("end game", WAITING, s_b);
    n = px_count;
    host_write(cell_word(CMD_START_GAME, '0, '0));
    waiting_on = "second sweep, vga_px_write stalled";
    while (px_count < n + 1000) begin
      @(posedge clk);
      #1;
    end
    c = ch_count;
    host_write(RESET_GAME);
    n = px_count;
    repeat (50) @(posedge clk);
    #1;
    if (px_count != n) flag_failure("pixel writes went on after the reset word");
    wait_chars(c + SCORE_DIGITS);
    check_digits("reset word", '0);
    check_status("reset word", WAITING, '0);
    close_test("end game and reset word", err0);

    $display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
